/* all.f */
design/l2_bus_pkg.sv
design/l2_tx_cfg_pkg.sv
design/l2_req_buffer.sv
design/l2_snoop_buffer.sv
design/l2_bus_driver.sv
design/l2_bus_tx.sv
sim/l2_bus_tx_assert.sv
sim/l2_bus_tx_tb.sv

/* sim/l2_bus_tx_tb.sv */
// l2 bus transmitter testbench
module l2_bus_tx_tb
  import l2_bus_pkg::*, l2_tx_cfg_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int TEST_COUNT  = 12;
  localparam int TEST_CYCLES = 64;

  logic       clk;
  logic       rst;
  logic       req_valid;
  bus_cmd_t   req_cmd;
  line_addr_t req_addr;
  bus_data_t  req_data;
  logic       req_ready;
  logic       snoop_valid;
  bus_tag_t   snoop_tag;
  line_addr_t snoop_addr;
  bus_data_t  snoop_data;
  logic       snoop_ready;
  logic       inv_valid;
  line_addr_t inv_addr;
  logic       flush_hit;
  logic       done_valid;
  seq_tag_t   done_tag;
  logic       bus_req;
  bus_cmd_t   bus_cmd;
  bus_tag_t   bus_tag;
  line_addr_t bus_addr;
  bus_data_t  bus_data;
  logic       bus_grant;
  logic       bus_nack;

  logic [2:0]  tb_slot;
  logic [31:0] rng;
  int          err_cnt;
  int          done_cnt;
  int          exp_done;
  seq_tag_t    exp_seq;
  bus_data_t   line_buf [LINE_BEATS];

  // what the bus model saw in the last granted slot
  bus_cmd_t    slot_cmd;
  bus_tag_t    slot_tag;
  line_addr_t  slot_addr;
  bus_data_t   slot_data [LINE_BEATS];
  logic        slot_done;
  seq_tag_t    slot_done_tag;
  logic        slot_ready;

  l2_bus_tx dut (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_cmd     (req_cmd),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .req_ready   (req_ready),
    .snoop_valid (snoop_valid),
    .snoop_tag   (snoop_tag),
    .snoop_addr  (snoop_addr),
    .snoop_data  (snoop_data),
    .snoop_ready (snoop_ready),
    .inv_valid   (inv_valid),
    .inv_addr    (inv_addr),
    .flush_hit   (flush_hit),
    .done_valid  (done_valid),
    .done_tag    (done_tag),
    .bus_req     (bus_req),
    .bus_cmd     (bus_cmd),
    .bus_tag     (bus_tag),
    .bus_addr    (bus_addr),
    .bus_data    (bus_data),
    .bus_grant   (bus_grant),
    .bus_nack    (bus_nack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // slot position counted from reset release
  always @(posedge clk) begin
    if (rst)
      tb_slot <= '0;
    else
      tb_slot <= tb_slot + 1'b1;
  end

  always @(posedge clk) begin
    if (!rst && done_valid)
      done_cnt <= done_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    err_cnt++;
    $display("[ERROR] %s: %s expected %0h, got %0h", test, what, exp, act);
  endtask

  task automatic fill_line();
    for (int k = 0; k < LINE_BEATS; k++) begin
      rng = xorshift32(rng);
      line_buf[k][63:32] = rng;
      rng = xorshift32(rng);
      line_buf[k][31:0] = rng;
    end
  endtask

  // flush beats follow the accept on consecutive cycles
  task automatic send_req(input bus_cmd_t cmd, input line_addr_t addr);
    while (req_ready !== 1'b1)
      @(negedge clk);
    req_valid = 1'b1;
    req_cmd   = cmd;
    req_addr  = addr;
    req_data  = line_buf[0];
    @(negedge clk);
    if (cmd == CMD_FLUSH) begin
      for (int k = 1; k < LINE_BEATS; k++) begin
        req_data = line_buf[k];
        @(negedge clk);
      end
    end
    req_valid = 1'b0;
  endtask

  task automatic send_snoop(input bus_tag_t tag, input line_addr_t addr);
    while (snoop_ready !== 1'b1)
      @(negedge clk);
    snoop_valid = 1'b1;
    snoop_tag   = tag;
    snoop_addr  = addr;
    for (int k = 0; k < LINE_BEATS; k++) begin
      snoop_data = line_buf[k];
      @(negedge clk);
    end
    snoop_valid = 1'b0;
  endtask

  task automatic wait_bus_req();
    while (bus_req !== 1'b1)
      @(negedge clk);
  endtask

  task automatic await_boundary();
    @(negedge clk);
    while (tb_slot != 3'd7)
      @(negedge clk);
  endtask

  // bus model grants at a boundary and records the slot
  task automatic run_slot(input logic nack);
    wait_bus_req();
    await_boundary();
    bus_grant = 1'b1;
    for (int k = 0; k < LINE_BEATS; k++) begin
      @(negedge clk);
      bus_grant = 1'b0;
      if (k == 0) begin
        slot_cmd  = bus_cmd;
        slot_tag  = bus_tag;
        slot_addr = bus_addr;
      end
      slot_data[k] = bus_data;
    end
    // nack only in the last slot cycle
    bus_nack = nack;
    #(CLK_PERIOD / 4);
    slot_done     = done_valid;
    slot_done_tag = done_tag;
    slot_ready    = req_ready;
    @(negedge clk);
    bus_nack = 1'b0;
  endtask

  task automatic check_req_slot(input string test, input bus_cmd_t cmd,
                                input line_addr_t addr);
    bus_tag_t exp_tag;
    exp_tag = {BUS_ID, exp_seq};
    if (slot_cmd !== cmd) report_mismatch(test, "bus_cmd", cmd, slot_cmd);
    if (slot_tag !== exp_tag) report_mismatch(test, "bus_tag", exp_tag, slot_tag);
    if (slot_addr !== addr) report_mismatch(test, "bus_addr", addr, slot_addr);
  endtask

  task automatic check_line(input string test);
    for (int k = 0; k < LINE_BEATS; k++) begin
      if (slot_data[k] !== line_buf[k])
        report_mismatch(test, $sformatf("beat %0d", k), line_buf[k], slot_data[k]);
    end
  endtask

  // next request uses the following sequence number
  task automatic check_done(input string test);
    if (slot_done !== 1'b1) report_mismatch(test, "done_valid", 1, slot_done);
    if (slot_done_tag !== exp_seq) report_mismatch(test, "done_tag", exp_seq, slot_done_tag);
    if (slot_ready !== 1'b1) report_mismatch(test, "req_ready at done", 1, slot_ready);
    exp_seq  = exp_seq + 1'b1;
    exp_done = exp_done + 1;
  endtask

  task automatic test_reset();
    if (bus_req !== 1'b0) report_mismatch("reset", "bus_req", 0, bus_req);
    if (done_valid !== 1'b0) report_mismatch("reset", "done_valid", 0, done_valid);
    if (flush_hit !== 1'b0) report_mismatch("reset", "flush_hit", 0, flush_hit);
    if (req_ready !== 1'b1) report_mismatch("reset", "req_ready", 1, req_ready);
    if (snoop_ready !== 1'b1) report_mismatch("reset", "snoop_ready", 1, snoop_ready);
  endtask

  task automatic test_read(input line_addr_t addr);
    send_req(CMD_BUSRD, addr);
    run_slot(1'b0);
    check_req_slot("read", CMD_BUSRD, addr);
    check_done("read");
  endtask

  task automatic test_flush(input line_addr_t addr);
    fill_line();
    send_req(CMD_FLUSH, addr);
    run_slot(1'b0);
    check_req_slot("flush", CMD_FLUSH, addr);
    check_line("flush");
    check_done("flush");
  endtask

  task automatic test_snoop_priority(input line_addr_t saddr, input line_addr_t raddr);
    bus_tag_t stag;
    stag = {2'd2, 3'd5};
    fill_line();
    send_snoop(stag, saddr);
    send_req(CMD_BUSRD, raddr);
    run_slot(1'b0);
    if (slot_cmd !== CMD_FLUSH) report_mismatch("snoop_prio", "bus_cmd", CMD_FLUSH, slot_cmd);
    if (slot_tag !== stag) report_mismatch("snoop_prio", "bus_tag", stag, slot_tag);
    if (slot_addr !== saddr) report_mismatch("snoop_prio", "bus_addr", saddr, slot_addr);
    if (slot_done !== 1'b0) report_mismatch("snoop_prio", "done_valid", 0, slot_done);
    check_line("snoop_prio");
    run_slot(1'b0);
    check_req_slot("snoop_prio", CMD_BUSRD, raddr);
    check_done("snoop_prio");
  endtask

  task automatic test_nack(input line_addr_t addr);
    int cnt;
    send_req(CMD_BUSRD, addr);
    cnt = done_cnt;
    run_slot(1'b1);
    check_req_slot("nack", CMD_BUSRD, addr);
    if (slot_done !== 1'b0) report_mismatch("nack", "done_valid", 0, slot_done);
    if (done_cnt != cnt) report_mismatch("nack", "done pulses", cnt, done_cnt);
    if (bus_req !== 1'b1) report_mismatch("nack", "bus_req after nack", 1, bus_req);
    if (req_ready !== 1'b0) report_mismatch("nack", "req_ready after nack", 0, req_ready);
    run_slot(1'b0);
    check_req_slot("nack", CMD_BUSRD, addr);
    if (done_cnt != cnt + 1) report_mismatch("nack", "done pulses", cnt + 1, done_cnt);
    check_done("nack");
  endtask

  task automatic test_inv_flush(input line_addr_t addr);
    fill_line();
    send_req(CMD_FLUSH, addr);
    wait_bus_req();
    inv_valid = 1'b1;
    inv_addr  = addr ^ 26'h1;
    #(CLK_PERIOD / 4);
    if (flush_hit !== 1'b0) report_mismatch("inv_flush", "flush_hit other line", 0, flush_hit);
    @(negedge clk);
    inv_addr = addr;
    #(CLK_PERIOD / 4);
    if (flush_hit !== 1'b1) report_mismatch("inv_flush", "flush_hit", 1, flush_hit);
    @(negedge clk);
    inv_valid = 1'b0;
    run_slot(1'b0);
    check_req_slot("inv_flush", CMD_FLUSH, addr);
    check_done("inv_flush");
  endtask

  // an invalidated upgrade has to fetch the line again
  task automatic test_upgrade(input logic do_inv, input line_addr_t addr);
    send_req(CMD_BUSUPGR, addr);
    wait_bus_req();
    inv_valid = do_inv;
    inv_addr  = addr;
    @(negedge clk);
    inv_valid = 1'b0;
    run_slot(1'b0);
    check_req_slot("upgrade", do_inv ? CMD_BUSRDX : CMD_BUSUPGR, addr);
    check_done("upgrade");
  endtask

  initial begin
    #(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog: tests did not finish within %0d cycles", TEST_COUNT * TEST_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_cmd     = '0;
    req_addr    = '0;
    req_data    = '0;
    snoop_valid = 1'b0;
    snoop_tag   = '0;
    snoop_addr  = '0;
    snoop_data  = '0;
    inv_valid   = 1'b0;
    inv_addr    = '0;
    bus_grant   = 1'b0;
    bus_nack    = 1'b0;
    rng         = 32'h4997;
    err_cnt     = 0;
    done_cnt    = 0;
    exp_done    = 0;
    exp_seq     = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_reset();
    // enough reads to wrap the sequence number
    for (int i = 0; i < 9; i++) begin
      rng = xorshift32(rng);
      test_read(rng[25:0]);
    end
    test_flush(26'h0c0ffee);
    test_snoop_priority(26'h15a5a5a, 26'h0123456);
    test_nack(26'h2222222);
    test_inv_flush(26'h3456789);
    test_upgrade(1'b0, 26'h0abcdef);
    test_upgrade(1'b1, 26'h1fedcba);
    repeat (2) @(negedge clk);
    if (done_cnt != exp_done)
      report_mismatch("summary", "done pulses", exp_done, done_cnt);
    err_cnt = err_cnt + dut.u_assert.fail_cnt;
    $display("errors: %0d, assertion failures: %0d, requests done: %0d",
             err_cnt, dut.u_assert.fail_cnt, done_cnt);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* sim/l2_bus_tx_assert.sv */
// transmitter bus protocol assertions
module l2_bus_tx_assert (
  input logic clk,
  input logic rst,
  input logic bus_req,
  input logic req_pending,
  input logic req_ready,
  input logic done_valid
);

  int fail_cnt = 0;

  // one pulse per finished request
  property done_single_p;
    @(posedge clk) disable iff (rst) done_valid |=> !done_valid;
  endproperty

  // a waiting request holds off the data path
  property req_hold_p;
    @(posedge clk) disable iff (rst) (bus_req && req_pending) |-> !req_ready;
  endproperty

  property reset_idle_p;
    @(posedge clk) rst |=> !bus_req;
  endproperty

  assert property (done_single_p) else begin
    fail_cnt++;
    $error("done_valid high on two cycles in a row");
  end

  assert property (req_hold_p) else begin
    fail_cnt++;
    $error("req_ready high while a request waits for the bus");
  end

  assert property (reset_idle_p) else begin
    fail_cnt++;
    $error("bus_req high in the cycle after reset");
  end

endmodule

bind l2_bus_tx l2_bus_tx_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .bus_req     (bus_req),
  .req_pending (req_pending),
  .req_ready   (req_ready),
  .done_valid  (done_valid)
);

/* design/l2_bus_tx.sv */
// l2 coherence bus transmitter
module l2_bus_tx import l2_bus_pkg::*, l2_tx_cfg_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       req_valid,
  input  bus_cmd_t   req_cmd,
  input  line_addr_t req_addr,
  input  bus_data_t  req_data,
  output logic       req_ready,

  input  logic       snoop_valid,
  input  bus_tag_t   snoop_tag,
  input  line_addr_t snoop_addr,
  input  bus_data_t  snoop_data,
  output logic       snoop_ready,

  input  logic       inv_valid,
  input  line_addr_t inv_addr,
  output logic       flush_hit,

  output logic       done_valid,
  output seq_tag_t   done_tag,

  output logic       bus_req,
  output bus_cmd_t   bus_cmd,
  output bus_tag_t   bus_tag,
  output line_addr_t bus_addr,
  output bus_data_t  bus_data,
  input  logic       bus_grant,
  input  logic       bus_nack
);

  logic       req_pending;
  bus_cmd_t   req_held_cmd;
  line_addr_t req_held_addr;
  bus_data_t  req_held_beat;
  logic       req_launch;
  logic       req_finish;
  logic       req_nack_ret;

  logic       snoop_pending;
  bus_tag_t   snoop_held_tag;
  line_addr_t snoop_held_addr;
  bus_data_t  snoop_held_beat;
  logic       snoop_launch;
  logic       snoop_finish;

  // read index is the slot position
  slot_cnt_t  rd_beat;

  l2_req_buffer u_req (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_cmd   (req_cmd),
    .req_addr  (req_addr),
    .req_data  (req_data),
    .req_ready (req_ready),
    .inv_valid (inv_valid),
    .inv_addr  (inv_addr),
    .flush_hit (flush_hit),
    .launch    (req_launch),
    .finish    (req_finish),
    .nack_ret  (req_nack_ret),
    .rd_beat   (rd_beat),
    .pending   (req_pending),
    .cmd       (req_held_cmd),
    .addr      (req_held_addr),
    .beat      (req_held_beat)
  );

  l2_snoop_buffer u_snoop (
    .clk         (clk),
    .rst         (rst),
    .snoop_valid (snoop_valid),
    .snoop_tag   (snoop_tag),
    .snoop_addr  (snoop_addr),
    .snoop_data  (snoop_data),
    .snoop_ready (snoop_ready),
    .launch      (snoop_launch),
    .finish      (snoop_finish),
    .rd_beat     (rd_beat),
    .pending     (snoop_pending),
    .tag         (snoop_held_tag),
    .addr        (snoop_held_addr),
    .beat        (snoop_held_beat)
  );

  l2_bus_driver u_drv (
    .clk           (clk),
    .rst           (rst),
    .req_pending   (req_pending),
    .req_cmd       (req_held_cmd),
    .req_addr      (req_held_addr),
    .req_beat      (req_held_beat),
    .snoop_pending (snoop_pending),
    .snoop_tag     (snoop_held_tag),
    .snoop_addr    (snoop_held_addr),
    .snoop_beat    (snoop_held_beat),
    .bus_req       (bus_req),
    .bus_cmd       (bus_cmd),
    .bus_tag       (bus_tag),
    .bus_addr      (bus_addr),
    .bus_data      (bus_data),
    .bus_grant     (bus_grant),
    .bus_nack      (bus_nack),
    .req_launch    (req_launch),
    .req_finish    (req_finish),
    .req_nack_ret  (req_nack_ret),
    .snoop_launch  (snoop_launch),
    .snoop_finish  (snoop_finish),
    .rd_beat       (rd_beat),
    .done_valid    (done_valid),
    .done_tag      (done_tag)
  );

endmodule

/* design/l2_bus_driver.sv */
// coherence bus slot driver
module l2_bus_driver import l2_bus_pkg::*, l2_tx_cfg_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       req_pending,
  input  bus_cmd_t   req_cmd,
  input  line_addr_t req_addr,
  input  bus_data_t  req_beat,

  input  logic       snoop_pending,
  input  bus_tag_t   snoop_tag,
  input  line_addr_t snoop_addr,
  input  bus_data_t  snoop_beat,

  output logic       bus_req,
  output bus_cmd_t   bus_cmd,
  output bus_tag_t   bus_tag,
  output line_addr_t bus_addr,
  output bus_data_t  bus_data,
  input  logic       bus_grant,
  input  logic       bus_nack,

  output logic       req_launch,
  output logic       req_finish,
  output logic       req_nack_ret,
  output logic       snoop_launch,
  output logic       snoop_finish,
  output beat_idx_t  rd_beat,

  output logic       done_valid,
  output seq_tag_t   done_tag
);

  slot_cnt_t slot_cnt;
  seq_tag_t  seq_q;
  logic      req_active;
  logic      snoop_active;
  logic      slot_end;
  logic      take;

  assign slot_end = (slot_cnt == slot_cnt_t'(SLOT_LAST));

  always_ff @(posedge clk) begin
    if (rst)
      slot_cnt <= '0;
    else if (slot_end)
      slot_cnt <= '0;
    else
      slot_cnt <= slot_cnt + 1'b1;
  end

  // grant is only looked at on the slot boundary
  assign bus_req      = req_pending || snoop_pending;
  assign take         = slot_end && bus_grant && bus_req;
  assign snoop_launch = take && snoop_pending;
  assign req_launch   = take && !snoop_pending && req_pending;

  // who owns the slot now running
  always_ff @(posedge clk) begin
    if (rst) begin
      req_active   <= 1'b0;
      snoop_active <= 1'b0;
    end else if (slot_end) begin
      req_active   <= req_launch;
      snoop_active <= snoop_launch;
    end
  end

  // nack sampled at the last cycle, snoops are never nacked
  assign snoop_finish = snoop_active && slot_end;
  assign req_finish   = req_active && slot_end && !bus_nack;
  assign req_nack_ret = req_active && slot_end && bus_nack;

  always_ff @(posedge clk) begin
    if (rst)
      seq_q <= '0;
    else if (req_finish)
      seq_q <= seq_q + 1'b1;
  end

  assign done_valid = req_finish;
  assign done_tag   = seq_q;

  // beat k goes out at slot cycle k
  assign rd_beat = beat_idx_t'(slot_cnt % LINE_BEATS);

  always_comb begin
    if (snoop_active) begin
      bus_cmd  = CMD_FLUSH;
      bus_tag  = snoop_tag;
      bus_addr = snoop_addr;
      bus_data = snoop_beat;
    end else if (req_active) begin
      bus_cmd  = req_cmd;
      bus_tag  = {BUS_ID, seq_q};
      bus_addr = req_addr;
      bus_data = req_beat;
    end else begin
      bus_cmd  = '0;
      bus_tag  = '0;
      bus_addr = '0;
      bus_data = '0;
    end
  end

endmodule

/* design/l2_snoop_buffer.sv */
// snoop response buffer
module l2_snoop_buffer import l2_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       snoop_valid,
  input  bus_tag_t   snoop_tag,
  input  line_addr_t snoop_addr,
  input  bus_data_t  snoop_data,
  output logic       snoop_ready,

  input  logic       launch,
  input  logic       finish,
  input  beat_idx_t  rd_beat,

  output logic       pending,
  output bus_tag_t   tag,
  output line_addr_t addr,
  output bus_data_t  beat
);

  buf_state_t state;
  beat_idx_t  fill_idx;
  bus_tag_t   tag_q;
  line_addr_t addr_q;
  bus_data_t  line_q [2**$bits(beat_idx_t)];

  logic accept;
  logic wr_beat;

  assign snoop_ready = (state == buf_idle) || finish;
  assign accept      = snoop_valid && snoop_ready;
  // every snoop response carries a full line
  assign wr_beat     = accept || ((state == buf_fill) && snoop_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= buf_idle;
      fill_idx <= '0;
    end else if (accept) begin
      state    <= buf_fill;
      fill_idx <= beat_idx_t'(1);
    end else begin
      case (state)
        buf_fill: begin
          if (snoop_valid) begin
            fill_idx <= fill_idx + 1'b1;
            if (fill_idx == '1)
              state <= buf_ready;
          end
        end
        buf_ready: begin
          if (launch)
            state <= buf_sending;
        end
        buf_sending: begin
          if (finish)
            state <= buf_idle;
        end
        default: ;
      endcase
    end
  end

  // requester's tag routes the flush back to it
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q  <= snoop_tag;
      addr_q <= snoop_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_beat)
      line_q[(state == buf_fill) ? fill_idx : beat_idx_t'(0)] <= snoop_data;
  end

  assign pending = (state == buf_ready);
  assign tag     = tag_q;
  assign addr    = addr_q;
  assign beat    = line_q[rd_beat];

endmodule

/* design/l2_req_buffer.sv */
// outgoing request buffer
module l2_req_buffer import l2_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       req_valid,
  input  bus_cmd_t   req_cmd,
  input  line_addr_t req_addr,
  input  bus_data_t  req_data,
  output logic       req_ready,

  input  logic       inv_valid,
  input  line_addr_t inv_addr,
  output logic       flush_hit,

  input  logic       launch,
  input  logic       finish,
  input  logic       nack_ret,
  input  beat_idx_t  rd_beat,

  output logic       pending,
  output bus_cmd_t   cmd,
  output line_addr_t addr,
  output bus_data_t  beat
);

  buf_state_t state;
  beat_idx_t  fill_idx;
  bus_cmd_t   cmd_q;
  line_addr_t addr_q;
  bus_data_t  line_q [2**$bits(beat_idx_t)];

  logic accept;
  logic wr_beat;
  logic inv_hit;
  logic upgr_hit;

  // slot end frees the entry in the same cycle
  assign req_ready = (state == buf_idle) || finish;
  assign accept    = req_valid && req_ready;

  // beat 0 comes with the accept, the rest during fill
  assign wr_beat = (accept && (req_cmd == CMD_FLUSH)) ||
                   ((state == buf_fill) && req_valid);

  assign inv_hit   = inv_valid && (state != buf_idle) && (inv_addr == addr_q);
  assign flush_hit = inv_hit && (cmd_q == CMD_FLUSH);
  // an upgrade already on the bus is left alone
  assign upgr_hit  = inv_hit && (cmd_q == CMD_BUSUPGR) && (state != buf_sending);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= buf_idle;
      fill_idx <= '0;
    end else if (accept) begin
      state    <= (req_cmd == CMD_FLUSH) ? buf_fill : buf_ready;
      fill_idx <= beat_idx_t'(1);
    end else begin
      case (state)
        buf_fill: begin
          if (req_valid) begin
            fill_idx <= fill_idx + 1'b1;
            if (fill_idx == '1)
              state <= buf_ready;
          end
        end
        buf_ready: begin
          if (launch)
            state <= buf_sending;
        end
        buf_sending: begin
          if (finish)
            state <= buf_idle;
          else if (nack_ret)
            state <= buf_ready;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q  <= req_cmd;
      addr_q <= req_addr;
    end else if (upgr_hit) begin
      // line was invalidated under us, need the data again
      cmd_q <= CMD_BUSRDX;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_beat)
      line_q[(state == buf_fill) ? fill_idx : beat_idx_t'(0)] <= req_data;
  end

  assign pending = (state == buf_ready);
  assign cmd     = cmd_q;
  assign addr    = addr_q;
  assign beat    = line_q[rd_beat];

endmodule

/* design/l2_tx_cfg_pkg.sv */
// transmitter build configuration
package l2_tx_cfg_pkg;

  // agent id of this l2 on the coherence bus
  localparam logic [1:0] BUS_ID = 2'd1;

  // beats in one cache line
  localparam int LINE_BEATS = 8;

  // last cycle of an 8-cycle bus slot
  localparam int SLOT_LAST = 7;

  // position inside the current slot
  typedef logic [2:0] slot_cnt_t;

endpackage

/* design/l2_bus_pkg.sv */
// coherence bus protocol types
package l2_bus_pkg;

  // bus command field
  typedef logic [2:0] bus_cmd_t;

  // read for a shared copy
  localparam bus_cmd_t CMD_BUSRD   = 3'd1;
  // read with intent to modify
  localparam bus_cmd_t CMD_BUSRDX  = 3'd2;
  // shared to modified, no data
  localparam bus_cmd_t CMD_BUSUPGR = 3'd3;
  // dirty line write-back, 8 beats follow
  localparam bus_cmd_t CMD_FLUSH   = 3'd4;

  // cache-line address, byte address bits 31..6
  typedef logic [25:0] line_addr_t;

  // one data beat on the bus
  typedef logic [63:0] bus_data_t;

  // agent id in the top two bits, sequence number below
  typedef logic [4:0] bus_tag_t;

  // per-agent request sequence number
  typedef logic [2:0] seq_tag_t;

  // position of a beat inside a line
  typedef logic [2:0] beat_idx_t;

  // one-entry buffer states
  typedef enum logic [1:0] {
    buf_idle,
    buf_fill,
    buf_ready,
    buf_sending
  } buf_state_t;

endpackage
